// File: Makefile
# Verilator flow for the tinys16 testbench

VERILATOR ?= verilator
TOP       ?= tb_tinys16
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
+incdir+src
src/tinys16_pkg.sv
src/tinys16_cen.sv
src/tinys16_timing.sv
src/tinys16_char.sv
src/tinys16_colmix.sv
src/tinys16_game.sv
dv/tb_clkgen.sv
dv/tb_tinys16.sv

// File: dv/tb_clkgen.sv
/* Clock with a 20 ns period. Reset is held low for 10 cycles */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
    end

    always #10 clk = ~clk;

endmodule

`default_nettype wire

// File: dv/tb_tinys16.sv
/* Self-checking testbench for tinys16_game. The ROM model answers 1 to 5
   clocks after each new address, inside the char layer's limit */
`timescale 1ns/1ps
`default_nettype none
`include "tinys16_defs.svh"

module tb_tinys16 import tinys16_pkg::*; ();

    localparam int FRAME_CYC = `H_TOTAL * `V_TOTAL * 2;
    localparam int SETUP_CYC = 4000;
    localparam int CYC_LIMIT = 3 * FRAME_CYC + SETUP_CYC;

    logic        clk;
    logic        arst_n;
    logic [12:1] cpu_addr;
    logic [15:0] cpu_dout;
    logic [1:0]  dsn;
    logic        rnw;
    logic        char_cs;
    logic        pal_cs;
    logic [15:0] char_dout;
    logic [15:0] pal_dout;
    logic [13:0] char_addr;
    logic [31:0] char_data = 32'h3c5a_a5c3;
    logic        char_ok = 1'b1;
    logic        pxl2_cen;
    logic        pxl_cen;
    logic [4:0]  red;
    logic [4:0]  green;
    logic [4:0]  blue;
    logic        LHBL_dly;
    logic        LVBL_dly;
    logic        HS;
    logic        VS;

    logic [15:0] map_copy [0:2**`MAP_AW-1];
    logic [15:0] pal_copy [0:2**`PAL_AW-1];
    logic [31:0] fill_rng = 32'd52815;
    logic [31:0] rom_rng = 32'd52815;
    logic [13:0] rom_cur = 14'd0;
    logic [2:0]  rom_wait = 3'd0;
    logic        check_on = 1'b0;
    logic        cen_run = 1'b0;
    logic        cen_phase = 1'b0;
    logic        lhbl_q = 1'b0;
    logic        lvbl_q = 1'b0;
    logic        hs_q = 1'b0;
    logic        vs_q = 1'b0;
    int          val_errs = 0;
    int          other_errs = 0;
    int          cycles = 0;
    int          px = 0;
    int          py = 0;
    int          h_cnt = 0;
    int          f_cnt = 0;
    int          hs_cnt = 0;
    int          vs_cnt = 0;

    tb_clkgen u_clkgen (.clk(clk), .arst_n(arst_n));

    tinys16_game dut_i (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        return r ^ (r << 5);
    endfunction

    // Scrambled graphics data, zero nibbles show up now and then
    function automatic logic [31:0] rom_word(input logic [13:0] a);
        logic [31:0] w;
        w = {18'd0, a} * 32'h9e37_79b1;
        return w ^ {w[15:0], w[31:16]} ^ 32'h3c5a_a5c3;
    endfunction

    function automatic logic [15:0] merge_bytes(input logic [15:0] old,
                                                input logic [15:0] data, input logic [1:0] be_n);
        return {be_n[1] ? old[15:8] : data[15:8], be_n[0] ? old[7:0] : data[7:0]};
    endfunction

    // Opaque flag, then palette index {colour[2:0], pixel}
    function automatic logic [7:0] pal_index(input int x, input int y);
        map_entry_u  e;
        logic [31:0] row;
        logic [3:0]  pix;
        e.raw = map_copy[{y[4:3], x[5:3]}];
        row   = rom_word({e.f.code, y[2:0], 2'b00});
        pix   = row[31 - 4 * (x % 8) -: 4];
        return {pix != 4'd0, e.f.color[2:0], pix};
    endfunction

    function automatic logic [14:0] expect_rgb(input int x, input int y);
        logic [7:0] p;
        if (x >= `H_VIS || y >= `V_VIS) begin
            return 15'd0;
        end
        p = pal_index(x, y);
        return p[7] ? pal_copy[p[6:0]][14:0] : 15'd0;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            val_errs++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic cpu_write(input logic pal, input int idx, input logic [15:0] data,
                             input logic [1:0] be_n);
        @(posedge clk);
        cpu_addr <= 12'(idx);
        cpu_dout <= data;
        dsn      <= be_n;
        rnw      <= 1'b0;
        char_cs  <= !pal;
        pal_cs   <= pal;
        if (pal) begin
            pal_copy[idx] = merge_bytes(pal_copy[idx], data, be_n);
        end else begin
            map_copy[idx] = merge_bytes(map_copy[idx], data, be_n);
        end
    endtask

    task automatic cpu_read(input logic pal, input int idx, output logic [15:0] data);
        @(posedge clk);
        cpu_addr <= 12'(idx);
        rnw      <= 1'b1;
        char_cs  <= 1'b0;
        pal_cs   <= 1'b0;
        dsn      <= 2'b11;
        @(posedge clk);
        @(negedge clk);
        data = pal ? pal_dout : char_dout;
    endtask

    // ROM drops char_ok on a new address and answers after a random delay
    always @(posedge clk) begin
        if (arst_n && char_addr != rom_cur) begin
            rom_cur  <= char_addr;
            char_ok  <= 1'b0;
            rom_wait <= 3'(rom_rng % 5 + 1);
            rom_rng  <= xorshift(rom_rng);
        end else if (rom_wait != 3'd0) begin
            rom_wait <= rom_wait - 3'd1;
            if (rom_wait == 3'd1) begin
                char_data <= rom_word(rom_cur);
                char_ok   <= 1'b1;
            end
        end
    end

    // One sample per pixel period, taken where the outputs are stable
    always @(negedge clk) begin
        // pxl2_cen stays high and pxl_cen alternates once the enables run
        if (cen_run) begin
            cen_phase = ~cen_phase;
            check_val("pxl2_cen", 32'd1, 32'(pxl2_cen));
            check_val("pxl_cen", 32'(cen_phase), 32'(pxl_cen));
        end
        if (arst_n && pxl_cen && !cen_run) begin
            cen_run   = 1'b1;
            cen_phase = 1'b1;
        end
        if (arst_n && pxl_cen) begin
            if (LHBL_dly && LVBL_dly) begin
                if (check_on) begin
                    check_val($sformatf("pixel x=%0d y=%0d", px, py),
                              32'(expect_rgb(px, py)), 32'({blue, green, red}));
                end
                px++;
            end else begin
                check_val("blanked rgb", 32'd0, 32'({blue, green, red}));
            end
            if (lhbl_q && !LHBL_dly) begin
                if (LVBL_dly) begin
                    check_val("visible pixels per line", `H_VIS, 32'(px));
                    py++;
                end
                px = 0;
            end
            if (lvbl_q && !LVBL_dly) begin
                check_val("visible lines per frame", `V_VIS, 32'(py));
                py = 0;
            end
            if (!lhbl_q && LHBL_dly) begin
                if (h_cnt > 0) check_val("line length", `H_TOTAL, 32'(h_cnt));
                h_cnt = 1;
            end else if (h_cnt > 0) begin
                h_cnt++;
            end
            if (!lvbl_q && LVBL_dly) begin
                if (f_cnt > 0) check_val("frame length", `H_TOTAL * `V_TOTAL, 32'(f_cnt));
                f_cnt = 1;
            end else if (f_cnt > 0) begin
                f_cnt++;
            end
            hs_cnt = HS ? hs_cnt + 1 : hs_cnt;
            vs_cnt = VS ? vs_cnt + 1 : vs_cnt;
            if (hs_q && !HS) begin
                check_val("hsync width", `HS_LEN, 32'(hs_cnt));
                hs_cnt = 0;
            end
            if (vs_q && !VS) begin
                check_val("vsync width", `VS_LEN * `H_TOTAL, 32'(vs_cnt));
                vs_cnt = 0;
            end
            lhbl_q = LHBL_dly;
            lvbl_q = LVBL_dly;
            hs_q   = HS;
            vs_q   = VS;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYC_LIMIT) begin
            other_errs++;
            $display("Timeout: frames did not complete within %0d cycles", CYC_LIMIT);
            $display("errors: value=%0d other=%0d", val_errs, other_errs);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        logic [15:0] rd;
        logic [7:0]  p;
        int          idx;
        cpu_addr = '0;
        cpu_dout = '0;
        dsn      = 2'b11;
        rnw      = 1'b1;
        char_cs  = 1'b0;
        pal_cs   = 1'b0;
        @(posedge arst_n);
        @(negedge clk);
        check_val("outputs after reset", 32'd0,
                  32'({HS, VS, LHBL_dly, LVBL_dly, red, green, blue}));
        for (int i = 0; i < 2**`MAP_AW; i++) begin
            fill_rng = xorshift(fill_rng);
            cpu_write(1'b0, i, fill_rng[15:0], 2'b00);
        end
        for (int i = 0; i < 2**`PAL_AW; i++) begin
            fill_rng = xorshift(fill_rng);
            cpu_write(1'b1, i, fill_rng[15:0], 2'b00);
        end
        // Single byte lanes on both memories
        for (int i = 0; i < 8; i++) begin
            fill_rng = xorshift(fill_rng);
            cpu_write(i[0], i * 3, fill_rng[15:0], {i[1], ~i[1]});
        end
        for (int i = 0; i < 2**`MAP_AW; i++) begin
            cpu_read(1'b0, i, rd);
            check_val($sformatf("map read %0d", i), 32'(map_copy[i]), 32'(rd));
        end
        for (int i = 0; i < 2**`PAL_AW; i++) begin
            cpu_read(1'b1, i, rd);
            check_val($sformatf("palette read %0d", i), 32'(pal_copy[i]), 32'(rd));
        end
        @(negedge LVBL_dly);
        check_on = 1'b1;
        @(posedge LVBL_dly);
        @(negedge LVBL_dly);
        // Recolour one entry seen on the top line, during vertical blank
        idx = 0;
        for (int x = `H_VIS - 1; x >= 0; x--) begin
            p = pal_index(x, 0);
            if (p[7]) idx = int'(p[6:0]);
        end
        cpu_write(1'b1, idx, ~pal_copy[idx], 2'b00);
        cpu_read(1'b1, idx, rd);
        check_val($sformatf("palette rewrite %0d", idx), 32'(pal_copy[idx]), 32'(rd));
        @(posedge LVBL_dly);
        @(negedge LVBL_dly);
        $display("errors: value=%0d other=%0d", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/tinys16_cen.sv
/* Pixel rate is half the master clock. pxl2_cen is high on every cycle
   once reset is released */
`timescale 1ns/1ps
`default_nettype none

module tinys16_cen (
    input  logic clk,
    input  logic arst_n,
    output logic pxl2_cen,
    output logic pxl_cen
);

    logic toggle;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            toggle   <= 1'b0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            toggle   <= ~toggle;
            pxl2_cen <= 1'b1;
            // High on every other cycle
            pxl_cen  <= toggle;
        end
    end

endmodule

`default_nettype wire

// File: src/tinys16_char.sv
/* Fixed 8x4 tilemap, no scroll. ROM must answer within 6 clocks of a new
   char_addr, otherwise the tile repeats the last row that arrived */
`timescale 1ns/1ps
`default_nettype none
`include "tinys16_defs.svh"

module tinys16_char import tinys16_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        pxl_cen,
    input  logic [6:0]  hdump,
    input  logic [5:0]  vdump,
    // CPU bus
    input  logic [12:1] cpu_addr,
    input  logic [15:0] cpu_dout,
    input  logic [1:0]  dsn,
    input  logic        rnw,
    input  logic        char_cs,
    output logic [15:0] char_dout,
    // Graphics ROM
    output logic [13:0] char_addr,
    input  logic [31:0] char_data,
    input  logic        char_ok,
    output pxl_t        pxl
);

    localparam logic [3:0] TILE_LAST = 4'(`H_TOTAL / 8 - 1);
    localparam logic [5:0] V_LAST    = 6'(`V_TOTAL - 1);

    logic [15:0]         map_ram [0:2**`MAP_AW-1];
    logic [`MAP_AW-1:0]  map_cpu_addr;
    logic [`MAP_AW-1:0]  map_rd_addr;
    map_entry_u          map_q;

    logic [3:0]  tile_h;
    logic        last_tile;
    logic [3:0]  next_col;
    logic [5:0]  fetch_v;

    logic [6:0]  col_req;
    logic        pending;
    logic        addr_new;
    logic [31:0] row_data;
    logic [6:0]  row_col;
    logic [31:0] shift;
    logic [6:0]  sh_col;

    assign map_cpu_addr = cpu_addr[`MAP_AW:1];

    // CPU port, byte writes under dsn
    always_ff @(posedge clk) begin
        if (char_cs && !rnw) begin
            if (!dsn[0]) begin
                map_ram[map_cpu_addr][7:0] <= cpu_dout[7:0];
            end
            if (!dsn[1]) begin
                map_ram[map_cpu_addr][15:8] <= cpu_dout[15:8];
            end
        end
        char_dout <= map_ram[map_cpu_addr];
    end

    // The tile after the current one, wrapping into the next line
    assign tile_h    = hdump[6:3];
    assign last_tile = tile_h == TILE_LAST;
    assign next_col  = last_tile ? 4'd0 : tile_h + 4'd1;

    always_comb begin
        fetch_v = vdump;
        if (last_tile) begin
            fetch_v = (vdump == V_LAST) ? 6'd0 : vdump + 6'd1;
        end
    end

    // Blanked columns and rows wrap onto the map and are masked later
    assign map_rd_addr = {fetch_v[4:3], next_col[2:0]};

    // Video read port, settled by the pxl_cen cycle of the same pixel
    always_ff @(posedge clk) begin
        map_q <= map_ram[map_rd_addr];
    end

    // Request at pixel 0, latch the ROM word once it is valid
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            char_addr <= 14'd0;
            pending   <= 1'b0;
            addr_new  <= 1'b0;
            row_data  <= 32'd0;
            row_col   <= 7'd0;
        end else if (pxl_cen && hdump[2:0] == 3'd0) begin
            char_addr <= {map_q.f.code, fetch_v[2:0], 2'b00};
            pending   <= 1'b1;
            addr_new  <= 1'b1;
        end else begin
            addr_new <= 1'b0;
            // char_ok may still refer to the old address on the first cycle
            if (pending && !addr_new && char_ok) begin
                row_data <= char_data;
                row_col  <= col_req;
                pending  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen && hdump[2:0] == 3'd0) begin
            col_req <= map_q.f.color;
        end
    end

    // Row shifter, most significant nibble is the leftmost pixel
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shift  <= 32'd0;
            sh_col <= 7'd0;
            pxl    <= '0;
        end else if (pxl_cen) begin
            pxl.color <= sh_col;
            pxl.pix   <= shift[31:28];
            if (hdump[2:0] == 3'd7) begin
                shift  <= row_data;
                sh_col <= row_col;
            end else begin
                shift <= {shift[27:0], 4'd0};
            end
        end
    end

endmodule

`default_nettype wire

// File: src/tinys16_colmix.sv
/* Palette words are xBBBBBGGGGGRRRRR. Only the low colour bits reach the
   palette, and pixel 0 is always black */
`timescale 1ns/1ps
`default_nettype none
`include "tinys16_defs.svh"

module tinys16_colmix import tinys16_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        pxl_cen,
    input  pxl_t        pxl,
    input  logic        HB,
    input  logic        VB,
    // CPU bus
    input  logic [12:1] cpu_addr,
    input  logic [15:0] cpu_dout,
    input  logic [1:0]  dsn,
    input  logic        rnw,
    input  logic        pal_cs,
    output logic [15:0] pal_dout,
    // Video out
    output logic [4:0]  red,
    output logic [4:0]  green,
    output logic [4:0]  blue,
    output logic        LHBL_dly,
    output logic        LVBL_dly
);

    logic [15:0]        pal_ram [0:2**`PAL_AW-1];
    logic [`PAL_AW-1:0] pal_cpu_addr;
    logic [`PAL_AW-1:0] pal_vaddr;

    logic [14:0] pal_q;
    logic        opaque;
    logic [14:0] rgb_m;
    logic [3:0]  lhbl_sr;
    logic [3:0]  lvbl_sr;
    logic        vis;

    assign pal_cpu_addr = cpu_addr[`PAL_AW:1];

    always_ff @(posedge clk) begin
        if (pal_cs && !rnw) begin
            if (!dsn[0]) begin
                pal_ram[pal_cpu_addr][7:0] <= cpu_dout[7:0];
            end
            if (!dsn[1]) begin
                pal_ram[pal_cpu_addr][15:8] <= cpu_dout[15:8];
            end
        end
        pal_dout <= pal_ram[pal_cpu_addr];
    end

    // Low colour bits and pixel value
    assign pal_vaddr = pxl[`PAL_AW-1:0];

    // Lookup then transparency, one pixel per stage
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pal_q  <= pal_ram[pal_vaddr][14:0];
            opaque <= |pxl.pix;
            rgb_m  <= opaque ? pal_q : 15'd0;
        end
    end

    // Blanking delay matches the pixel path
    assign vis = lhbl_sr[2] & lvbl_sr[2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lhbl_sr <= 4'd0;
            lvbl_sr <= 4'd0;
            red     <= 5'd0;
            green   <= 5'd0;
            blue    <= 5'd0;
        end else if (pxl_cen) begin
            lhbl_sr <= {lhbl_sr[2:0], ~HB};
            lvbl_sr <= {lvbl_sr[2:0], ~VB};
            red     <= vis ? rgb_m[4:0]   : 5'd0;
            green   <= vis ? rgb_m[9:5]   : 5'd0;
            blue    <= vis ? rgb_m[14:10] : 5'd0;
        end
    end

    assign LHBL_dly = lhbl_sr[3];
    assign LVBL_dly = lvbl_sr[3];

endmodule

`default_nettype wire

// File: src/tinys16_defs.svh
/* Raster is shrunk for short simulations. Sync pulses sit inside blanking,
   and the tilemap covers only the visible 8x4 tiles */
`ifndef TINYS16_DEFS_SVH
`define TINYS16_DEFS_SVH

// Horizontal raster, in pixel periods
`define H_TOTAL  96
`define H_VIS    64
`define HS_START 72
`define HS_LEN   8

// Vertical raster, in lines
`define V_TOTAL  40
`define V_VIS    32
`define VS_START 34
`define VS_LEN   2

// Tilemap is 8 columns by 4 rows of 8x8 tiles
`define MAP_AW   5

// 8 palettes of 16 colours
`define PAL_AW   7

`endif

// File: src/tinys16_game.sv
/* CPU bus comes straight from the ports. RGB leaves 4 pixel periods after
   the matching hdump */
`timescale 1ns/1ps
`default_nettype none

module tinys16_game import tinys16_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    // CPU bus
    input  logic [12:1] cpu_addr,
    input  logic [15:0] cpu_dout,
    input  logic [1:0]  dsn,
    input  logic        rnw,
    input  logic        char_cs,
    input  logic        pal_cs,
    output logic [15:0] char_dout,
    output logic [15:0] pal_dout,
    // Graphics ROM
    output logic [13:0] char_addr,
    input  logic [31:0] char_data,
    input  logic        char_ok,
    // Video
    output logic        pxl2_cen,
    output logic        pxl_cen,
    output logic [4:0]  red,
    output logic [4:0]  green,
    output logic [4:0]  blue,
    output logic        LHBL_dly,
    output logic        LVBL_dly,
    output logic        HS,
    output logic        VS
);

    logic [6:0] hdump;
    logic [5:0] vdump;
    logic       HB;
    logic       VB;
    pxl_t       pxl;

    tinys16_cen u_cen (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .pxl2_cen ( pxl2_cen ),
        .pxl_cen  ( pxl_cen  )
    );

    tinys16_timing u_timing (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .pxl_cen ( pxl_cen ),
        .hdump   ( hdump   ),
        .vdump   ( vdump   ),
        .HB      ( HB      ),
        .VB      ( VB      ),
        .HS      ( HS      ),
        .VS      ( VS      )
    );

    tinys16_char u_char (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .pxl_cen   ( pxl_cen   ),
        .hdump     ( hdump     ),
        .vdump     ( vdump     ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_dout  ( cpu_dout  ),
        .dsn       ( dsn       ),
        .rnw       ( rnw       ),
        .char_cs   ( char_cs   ),
        .char_dout ( char_dout ),
        .char_addr ( char_addr ),
        .char_data ( char_data ),
        .char_ok   ( char_ok   ),
        .pxl       ( pxl       )
    );

    tinys16_colmix u_colmix (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .pxl_cen  ( pxl_cen  ),
        .pxl      ( pxl      ),
        .HB       ( HB       ),
        .VB       ( VB       ),
        .cpu_addr ( cpu_addr ),
        .cpu_dout ( cpu_dout ),
        .dsn      ( dsn      ),
        .rnw      ( rnw      ),
        .pal_cs   ( pal_cs   ),
        .pal_dout ( pal_dout ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .LHBL_dly ( LHBL_dly ),
        .LVBL_dly ( LVBL_dly )
    );

endmodule

`default_nettype wire

// File: src/tinys16_pkg.sv
/* Tilemap word layout and the pixel index passed from the char layer to
   the palette stage */
`default_nettype none

package tinys16_pkg;

    // Colour in the upper bits, tile code below
    typedef struct packed {
        logic [6:0] color;
        logic [8:0] code;
    } map_fields_t;

    // CPU sees the raw word, the video side sees the fields
    typedef union packed {
        logic [15:0] raw;
        map_fields_t f;
    } map_entry_u;

    // Palette index before the lookup
    typedef struct packed {
        logic [6:0] color;
        logic [3:0] pix;
    } pxl_t;

endpackage

`default_nettype wire

// File: src/tinys16_timing.sv
/* Counters and flags advance only on pxl_cen. HB, VB, HS and VS are
   registered together with hdump and vdump, so they line up */
`timescale 1ns/1ps
`default_nettype none
`include "tinys16_defs.svh"

module tinys16_timing (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       pxl_cen,
    output logic [6:0] hdump,
    output logic [5:0] vdump,
    output logic       HB,
    output logic       VB,
    output logic       HS,
    output logic       VS
);

    localparam logic [6:0] H_LAST   = 7'(`H_TOTAL - 1);
    localparam logic [6:0] H_VIS    = 7'(`H_VIS);
    localparam logic [6:0] HS_START = 7'(`HS_START);
    localparam logic [6:0] HS_END   = 7'(`HS_START + `HS_LEN);
    localparam logic [5:0] V_LAST   = 6'(`V_TOTAL - 1);
    localparam logic [5:0] V_VIS    = 6'(`V_VIS);
    localparam logic [5:0] VS_START = 6'(`VS_START);
    localparam logic [5:0] VS_END   = 6'(`VS_START + `VS_LEN);

    logic [6:0] h_nxt;
    logic [5:0] v_nxt;
    logic       line_end;

    assign line_end = hdump == H_LAST;
    assign h_nxt    = line_end ? 7'd0 : hdump + 7'd1;

    // Vertical count moves on at the end of each line
    always_comb begin
        v_nxt = vdump;
        if (line_end) begin
            v_nxt = (vdump == V_LAST) ? 6'd0 : vdump + 6'd1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hdump <= 7'd0;
            vdump <= 6'd0;
            HB    <= 1'b0;
            VB    <= 1'b0;
            HS    <= 1'b0;
            VS    <= 1'b0;
        end else if (pxl_cen) begin
            hdump <= h_nxt;
            vdump <= v_nxt;
            // Flags from the next count so they match the new position
            HB    <= h_nxt >= H_VIS;
            VB    <= v_nxt >= V_VIS;
            HS    <= (h_nxt >= HS_START) && (h_nxt < HS_END);
            VS    <= (v_nxt >= VS_START) && (v_nxt < VS_END);
        end
    end

endmodule

`default_nettype wire
